//--- OramPkg.sv
// Shared definitions for the Path ORAM backend
// Tree geometry, slot word layout, command and state encodings, keyed pad
package OramPkg;

	// ----------------------------------------------------------
	// Tree geometry
	// ----------------------------------------------------------
	localparam int OramL = 2;
	localparam int OramZ = 2;
	localparam int NumBuckets = 7;
	localparam int NumSlots = NumBuckets * OramZ;
	localparam int PathSlots = (OramL + 1) * OramZ;
	localparam int LevelW = $clog2(OramL + 1);
	localparam int SlotIdxW = $clog2(OramZ);

	// ----------------------------------------------------------
	// Widths and slot word layout
	// ----------------------------------------------------------
	localparam int AddrW = 4;
	localparam int DataW = 32;
	localparam int DramAW = 4;
	localparam int StashSize = 8;
	localparam int CountW = $clog2(StashSize + 1);

	// {valid, program address, leaf, data}
	localparam int SlotW = 1 + AddrW + OramL + DataW;
	localparam int ValidBit = SlotW - 1;
	localparam int AddrLsb = OramL + DataW;
	localparam int LeafLsb = DataW;

	localparam logic [SlotW-1:0] CipherKey = 39'h5A_C3E1_9B27;

	typedef enum logic [1:0] {
		Write = 2'd0,
		Append = 2'd1,
		Read = 2'd2
	} backendCmd_t;

	typedef enum logic [2:0] {
		Init,
		Idle,
		ReadPath,
		Serve,
		TakeStore,
		WriteBack,
		Respond
	} ctrlState_t;

	typedef enum logic {
		DramWrite = 1'b0,
		DramRead = 1'b1
	} dramCmd_t;

	// Key rotated left by 3*addr, then XOR with addr repeated over the word
	function automatic logic [SlotW-1:0] cipherPad(input logic [DramAW-1:0] addr);
		logic [2*SlotW-1:0] dbl;
		logic [10*DramAW-1:0] rep;
		int rot;
		rot = (3 * int'(addr)) % SlotW;
		dbl = {CipherKey, CipherKey} << rot;
		rep = {10{addr}};
		return dbl[2*SlotW-1:SlotW] ^ rep[SlotW-1:0];
	endfunction

endpackage

//--- PathAddrGen.sv
// Path address generator
// Maps leaf, level and slot to a DRAM slot word, and tests if a block's leaf fits a bucket
`timescale 1ns/1ps

module PathAddrGen
	import OramPkg::*;
(
	input logic [OramL-1:0] leaf,
	input logic [LevelW-1:0] level,
	input logic [SlotIdxW-1:0] slot,
	input logic [OramL-1:0] candLeaf,
	output logic [DramAW-1:0] slotAddr,
	output logic fits
);

	logic [LevelW-1:0] shift;
	logic [DramAW-1:0] bucket;

	// Distance from this level down to the leaves
	assign shift = LevelW'(OramL) - level;

	// Heap order, level l starts at bucket 2^l - 1
	assign bucket = DramAW'((1 << level) - 1) + DramAW'(leaf >> shift);
	assign slotAddr = DramAW'(bucket * OramZ) + DramAW'(slot);

	// Same top level bits means the bucket lies on both paths
	assign fits = (candLeaf >> shift) == (leaf >> shift);

endmodule

//--- Stash.sv
// Path ORAM stash
// Fully associative store for real blocks between path read and write-back
`timescale 1ns/1ps

module Stash
	import OramPkg::*;
(
	input logic Clock,
	input logic rst,
	input logic insValid,
	input logic [AddrW-1:0] insAddr,
	input logic [OramL-1:0] insLeaf,
	input logic [DataW-1:0] insData,
	input logic [AddrW-1:0] lookAddr,
	output logic lookHit,
	output logic [DataW-1:0] lookData,
	input logic updValid,
	input logic [DataW-1:0] updData,
	input logic [OramL-1:0] updLeaf,
	input logic [OramL-1:0] evLeaf,
	input logic [LevelW-1:0] evLevel,
	output logic evValid,
	output logic [AddrW-1:0] evAddr,
	output logic [OramL-1:0] evBlockLeaf,
	output logic [DataW-1:0] evData,
	input logic evTake,
	output logic [CountW-1:0] count
);

	localparam int IdxW = $clog2(StashSize);

	logic [StashSize-1:0] valid;
	logic [AddrW-1:0] addrMem [StashSize];
	logic [OramL-1:0] leafMem [StashSize];
	logic [DataW-1:0] dataMem [StashSize];
	logic [StashSize-1:0] fitVec;
	logic [IdxW-1:0] lookIdx;
	logic [IdxW-1:0] hitIdx;
	logic [IdxW-1:0] freeIdx;
	logic [IdxW-1:0] insIdx;
	logic [IdxW-1:0] evIdx;
	logic insHit;
	logic insFree;

	// Bucket fit test per entry
	for (genvar i = 0; i < StashSize; i++) begin : gFit
		PathAddrGen fitGen (
			.leaf(evLeaf),
			.level(evLevel),
			.slot('0),
			.candLeaf(leafMem[i]),
			.slotAddr(),
			.fits(fitVec[i])
		);
	end

	// ----------------------------------------------------------
	// Searches, lowest matching entry wins
	// ----------------------------------------------------------
	always_comb begin
		lookHit = 1'b0;
		lookIdx = '0;
		insHit = 1'b0;
		hitIdx = '0;
		insFree = 1'b0;
		freeIdx = '0;
		evValid = 1'b0;
		evIdx = '0;
		count = '0;
		for (int i = StashSize - 1; i >= 0; i--) begin
			if (valid[i] && addrMem[i] == lookAddr) begin
				lookHit = 1'b1;
				lookIdx = IdxW'(i);
			end
			if (valid[i] && addrMem[i] == insAddr) begin
				insHit = 1'b1;
				hitIdx = IdxW'(i);
			end
			if (!valid[i]) begin
				insFree = 1'b1;
				freeIdx = IdxW'(i);
			end
			if (valid[i] && fitVec[i]) begin
				evValid = 1'b1;
				evIdx = IdxW'(i);
			end
			count = count + CountW'(valid[i]);
		end
	end

	// Existing address is overwritten in place
	assign insIdx = insHit ? hitIdx : freeIdx;

	assign lookData = dataMem[lookIdx];
	assign evAddr = addrMem[evIdx];
	assign evBlockLeaf = leafMem[evIdx];
	assign evData = dataMem[evIdx];

	always_ff @(posedge Clock) begin
		if (rst) begin
			valid <= '0;
		end else begin
			if (evTake && evValid)
				valid[evIdx] <= 1'b0;
			if (insValid && (insHit || insFree))
				valid[insIdx] <= 1'b1;
		end
	end

	always_ff @(posedge Clock) begin
		if (insValid && (insHit || insFree)) begin
			addrMem[insIdx] <= insAddr;
			leafMem[insIdx] <= insLeaf;
			dataMem[insIdx] <= insData;
		end
		if (updValid && lookHit) begin
			leafMem[lookIdx] <= updLeaf;
			dataMem[lookIdx] <= updData;
		end
	end

	// Path read plus serve must never push past capacity
	assert property (@(posedge Clock) disable iff (rst)
		insValid |-> insHit || count < CountW'(StashSize))
		else $error("stash overflow on insert of addr %h", insAddr);

endmodule

//--- BucketCipher.sv
// Slot word cipher
// XOR with the keyed pad of the slot address, one register stage per direction
`timescale 1ns/1ps

module BucketCipher
	import OramPkg::*;
(
	input logic Clock,
	input logic rst,
	input logic [SlotW-1:0] encIn,
	input logic [DramAW-1:0] encAddr,
	input logic encValid,
	output logic [SlotW-1:0] encOut,
	output logic encOutValid,
	input logic [SlotW-1:0] decIn,
	input logic [DramAW-1:0] decAddr,
	input logic decValid,
	output logic [SlotW-1:0] decOut,
	output logic decOutValid
);

	always_ff @(posedge Clock) begin
		if (rst) begin
			encOutValid <= 1'b0;
			decOutValid <= 1'b0;
		end else begin
			encOutValid <= encValid;
			decOutValid <= decValid;
		end
	end

	// Words hold until the next strobe, so DRAM stalls see a stable value
	always_ff @(posedge Clock) begin
		if (encValid)
			encOut <= encIn ^ cipherPad(encAddr);
		if (decValid)
			decOut <= decIn ^ cipherPad(decAddr);
	end

endmodule

//--- BackendCtrl.sv
// Path ORAM backend sequencer
// DRAM init, path read, block service, path write-back and frontend handshakes
`timescale 1ns/1ps

module BackendCtrl
	import OramPkg::*;
(
	input logic Clock,
	input logic rst,
	input backendCmd_t Command,
	input logic [AddrW-1:0] PAddr,
	input logic [OramL-1:0] CurrentLeaf,
	input logic [OramL-1:0] RemappedLeaf,
	input logic CommandValid,
	output logic CommandReady,
	output logic [DataW-1:0] LoadData,
	output logic LoadValid,
	input logic LoadReady,
	input logic [DataW-1:0] StoreData,
	input logic StoreValid,
	output logic StoreReady,
	output logic [DramAW-1:0] DRAMCommandAddress,
	output dramCmd_t DRAMCommand,
	output logic DRAMCommandValid,
	input logic DRAMCommandReady,
	input logic DRAMReadDataValid,
	output logic DRAMReadDataReady,
	output logic DRAMWriteDataValid,
	input logic DRAMWriteDataReady,
	output logic insValid,
	output logic [AddrW-1:0] insAddr,
	output logic [OramL-1:0] insLeaf,
	output logic [DataW-1:0] insData,
	output logic [AddrW-1:0] lookAddr,
	input logic lookHit,
	input logic [DataW-1:0] lookData,
	output logic updValid,
	output logic [DataW-1:0] updData,
	output logic [OramL-1:0] updLeaf,
	output logic [OramL-1:0] evLeaf,
	output logic [LevelW-1:0] evLevel,
	input logic evValid,
	input logic [AddrW-1:0] evAddr,
	input logic [OramL-1:0] evBlockLeaf,
	input logic [DataW-1:0] evData,
	output logic evTake,
	output logic [SlotW-1:0] encIn,
	output logic [DramAW-1:0] encAddr,
	output logic encValid,
	input logic encOutValid,
	output logic [DramAW-1:0] decAddr,
	output logic decValid,
	input logic [SlotW-1:0] decOut,
	input logic decOutValid
);

	localparam int WordW = $clog2(NumSlots + 1);
	localparam int RetW = $clog2(PathSlots + 1);

	ctrlState_t state;
	backendCmd_t cmdQ;
	logic [AddrW-1:0] addrQ;
	logic [OramL-1:0] curLeafQ;
	logic [OramL-1:0] remapQ;
	logic [DataW-1:0] loadQ;
	logic [WordW-1:0] wordCnt;
	logic [WordW-1:0] wordLimit;
	logic [RetW-1:0] retCnt;
	logic [DramAW-1:0] rdAddrQ [PathSlots];
	logic [LevelW-1:0] genLevel;
	logic [SlotIdxW-1:0] genSlot;
	logic [DramAW-1:0] genAddr;
	logic [DramAW-1:0] wordAddr;
	logic wrIdle;
	logic launch;
	logic issueRead;
	logic retFire;

	// ----------------------------------------------------------
	// Word sequencing, leaf level first
	// ----------------------------------------------------------
	assign genLevel = LevelW'(OramL - int'(wordCnt) / OramZ);
	assign genSlot = SlotIdxW'(int'(wordCnt) % OramZ);

	PathAddrGen cmdGen (
		.leaf(curLeafQ),
		.level(genLevel),
		.slot(genSlot),
		.candLeaf(curLeafQ),
		.slotAddr(genAddr),
		.fits()
	);

	assign wordAddr = (state == Init) ? DramAW'(wordCnt) : genAddr;
	assign wordLimit = (state == Init) ? WordW'(NumSlots) : WordW'(PathSlots);
	assign wrIdle = !encOutValid && !DRAMCommandValid && !DRAMWriteDataValid;
	assign launch = (state == Init || state == WriteBack) && wrIdle && wordCnt < wordLimit;
	assign issueRead = state == ReadPath && !DRAMCommandValid && int'(wordCnt) < PathSlots;
	assign retFire = DRAMReadDataValid && DRAMReadDataReady;

	assign CommandReady = state == Idle;
	assign StoreReady = state == TakeStore;
	assign LoadValid = state == Respond;
	assign LoadData = loadQ;
	assign DRAMReadDataReady = state == ReadPath;

	// Write-back slot gets the lowest fitting block, or an empty word
	assign evLeaf = curLeafQ;
	assign evLevel = genLevel;
	assign evTake = launch && state == WriteBack && evValid;
	assign encValid = launch;
	assign encAddr = wordAddr;
	assign encIn = (state == WriteBack && evValid) ? {1'b1, evAddr, evBlockLeaf, evData} : '0;

	// Returns come back in command order
	assign decValid = retFire;
	assign decAddr = rdAddrQ[retCnt];
	assign lookAddr = addrQ;

	always_comb begin
		insValid = 1'b0;
		insAddr = addrQ;
		insLeaf = remapQ;
		insData = '0;
		updValid = 1'b0;
		updData = lookData;
		updLeaf = remapQ;
		case (state)
			ReadPath: begin
				insValid = decOutValid && decOut[ValidBit];
				insAddr = decOut[AddrLsb +: AddrW];
				insLeaf = decOut[LeafLsb +: OramL];
				insData = decOut[DataW-1:0];
			end
			// Miss creates the block with zero data
			Serve: begin
				insValid = !lookHit;
				updValid = lookHit;
			end
			TakeStore: begin
				insValid = StoreValid && cmdQ == Append;
				insData = StoreData;
				updValid = StoreValid && cmdQ != Append;
				updData = StoreData;
			end
			default: begin
				insValid = 1'b0;
			end
		endcase
	end

	// ----------------------------------------------------------
	// FSM and DRAM handshakes
	// ----------------------------------------------------------
	always_ff @(posedge Clock) begin
		if (rst) begin
			state <= Init;
			wordCnt <= '0;
			retCnt <= '0;
			DRAMCommandValid <= 1'b0;
			DRAMWriteDataValid <= 1'b0;
		end else begin
			if (DRAMCommandValid && DRAMCommandReady)
				DRAMCommandValid <= 1'b0;
			if (DRAMWriteDataValid && DRAMWriteDataReady)
				DRAMWriteDataValid <= 1'b0;
			// Encrypted word ready, offer command and data together
			if (encOutValid) begin
				DRAMCommandValid <= 1'b1;
				DRAMWriteDataValid <= 1'b1;
			end
			if (issueRead)
				DRAMCommandValid <= 1'b1;
			if (launch || issueRead)
				wordCnt <= wordCnt + 1'b1;
			if (retFire)
				retCnt <= retCnt + 1'b1;
			case (state)
				Init: begin
					if (int'(wordCnt) == NumSlots && wrIdle)
						state <= Idle;
				end
				Idle: begin
					wordCnt <= '0;
					retCnt <= '0;
					if (CommandValid) begin
						if (Command == Append)
							state <= TakeStore;
						else
							state <= ReadPath;
					end
				end
				// Last decrypted word lands in the stash before Serve
				ReadPath: begin
					if (int'(retCnt) == PathSlots && !decOutValid) begin
						state <= Serve;
						wordCnt <= '0;
					end
				end
				Serve: begin
					if (cmdQ == Write)
						state <= TakeStore;
					else
						state <= WriteBack;
				end
				TakeStore: begin
					if (StoreValid) begin
						if (cmdQ == Append)
							state <= Idle;
						else
							state <= WriteBack;
					end
				end
				WriteBack: begin
					if (int'(wordCnt) == PathSlots && wrIdle) begin
						if (cmdQ == Read)
							state <= Respond;
						else
							state <= Idle;
					end
				end
				Respond: begin
					if (LoadReady)
						state <= Idle;
				end
				default: begin
					state <= Idle;
				end
			endcase
		end
	end

	always_ff @(posedge Clock) begin
		if (CommandValid && CommandReady) begin
			cmdQ <= Command;
			addrQ <= PAddr;
			curLeafQ <= CurrentLeaf;
			remapQ <= RemappedLeaf;
		end
		if (launch)
			DRAMCommand <= DramWrite;
		else if (issueRead)
			DRAMCommand <= DramRead;
		if (launch || issueRead)
			DRAMCommandAddress <= wordAddr;
		if (issueRead)
			rdAddrQ[wordCnt[RetW-1:0]] <= genAddr;
		if (state == Serve)
			loadQ <= lookHit ? lookData : '0;
	end

	// A Write reaches write-back only once its store word updated a stash entry
	assert property (@(posedge Clock) disable iff (rst)
		$rose(state == WriteBack) && cmdQ == Write |-> $past(updValid && lookHit))
		else $error("write entered write-back without updating the stash");

	// Stalled write data blocks any new DRAM command
	assert property (@(posedge Clock) disable iff (rst)
		DRAMWriteDataValid && !DRAMWriteDataReady |=> !$rose(DRAMCommandValid))
		else $error("DRAM command issued while write data pending");

endmodule

//--- PathOramBackend.sv
// Path ORAM backend top level
// Controller, stash and slot cipher between the frontend and DRAM ports
`timescale 1ns/1ps

module PathOramBackend
	import OramPkg::*;
(
	input logic Clock,
	input logic rst,
	input backendCmd_t Command,
	input logic [AddrW-1:0] PAddr,
	input logic [OramL-1:0] CurrentLeaf,
	input logic [OramL-1:0] RemappedLeaf,
	input logic CommandValid,
	output logic CommandReady,
	output logic [DataW-1:0] LoadData,
	output logic LoadValid,
	input logic LoadReady,
	input logic [DataW-1:0] StoreData,
	input logic StoreValid,
	output logic StoreReady,
	output logic [DramAW-1:0] DRAMCommandAddress,
	output dramCmd_t DRAMCommand,
	output logic DRAMCommandValid,
	input logic DRAMCommandReady,
	input logic [SlotW-1:0] DRAMReadData,
	input logic DRAMReadDataValid,
	output logic DRAMReadDataReady,
	output logic [SlotW-1:0] DRAMWriteData,
	output logic DRAMWriteDataValid,
	input logic DRAMWriteDataReady
);

	// ----------------------------------------------------------
	// Stash controls
	// ----------------------------------------------------------
	logic insValid;
	logic [AddrW-1:0] insAddr;
	logic [OramL-1:0] insLeaf;
	logic [DataW-1:0] insData;
	logic [AddrW-1:0] lookAddr;
	logic lookHit;
	logic [DataW-1:0] lookData;
	logic updValid;
	logic [DataW-1:0] updData;
	logic [OramL-1:0] updLeaf;
	logic [OramL-1:0] evLeaf;
	logic [LevelW-1:0] evLevel;
	logic evValid;
	logic [AddrW-1:0] evAddr;
	logic [OramL-1:0] evBlockLeaf;
	logic [DataW-1:0] evData;
	logic evTake;

	// ----------------------------------------------------------
	// Cipher controls
	// ----------------------------------------------------------
	logic [SlotW-1:0] encIn;
	logic [DramAW-1:0] encAddr;
	logic encValid;
	logic encOutValid;
	logic [DramAW-1:0] decAddr;
	logic decValid;
	logic [SlotW-1:0] decOut;
	logic decOutValid;

	BackendCtrl ctrl (.*);

	Stash stash (
		.count(),
		.*
	);

	// Read data decrypts straight off the DRAM port, write data leaves encrypted
	BucketCipher cipher (
		.decIn(DRAMReadData),
		.encOut(DRAMWriteData),
		.*
	);

endmodule

//--- DramModel.sv
// Testbench DRAM model
// Slot-word array behind valid/ready ports, with random ready stalls
`timescale 1ns/1ps

module DramModel
	import OramPkg::*;
#(
	parameter int Seed = 32'hf209
) (
	input logic Clock,
	input logic rst,
	input logic stallEn,
	input logic [DramAW-1:0] cmdAddr,
	input dramCmd_t cmd,
	input logic cmdValid,
	output logic cmdReady,
	output logic [SlotW-1:0] rdData,
	output logic rdValid,
	input logic rdReady,
	input logic [SlotW-1:0] wrData,
	input logic wrValid,
	output logic wrReady,
	input logic [DramAW-1:0] peekAddr,
	output logic [SlotW-1:0] peekData
);

	logic [SlotW-1:0] mem [NumSlots];
	logic [DramAW-1:0] rdQ [$];
	logic [DramAW-1:0] wrAddrQ [$];
	logic [SlotW-1:0] wrDataQ [$];
	logic rstSeen = 1'b1;
	logic rdTaken = 1'b0;
	logic cmdRdyQ = 1'b0;
	logic wrRdyQ = 1'b0;
	logic rdValidQ = 1'b0;
	logic [SlotW-1:0] rdDataQ = '0;
	integer seed = Seed;
	logic [31:0] r;

	assign cmdReady = cmdRdyQ;
	assign wrReady = wrRdyQ;
	assign rdValid = rdValidQ;
	assign rdData = rdDataQ;
	assign peekData = mem[peekAddr];

	always @(Clock) begin
		if (Clock) begin
			// Handshakes completed on this rising edge
			rstSeen = rst;
			if (cmdValid && cmdRdyQ) begin
				if (cmd == DramRead)
					rdQ.push_back(cmdAddr);
				else
					wrAddrQ.push_back(cmdAddr);
			end
			if (wrValid && wrRdyQ)
				wrDataQ.push_back(wrData);
			if (rdValidQ && rdReady)
				rdTaken = 1'b1;
		end else if (rstSeen) begin
			// Junk contents until init overwrites them
			for (int i = 0; i < NumSlots; i++)
				mem[i] = {SlotW{1'b1}} ^ (SlotW'(i) * 39'h10_2040_8101);
			rdQ.delete();
			wrAddrQ.delete();
			wrDataQ.delete();
			rdTaken = 1'b0;
			rdValidQ = 1'b0;
			cmdRdyQ = 1'b0;
			wrRdyQ = 1'b0;
		end else begin
			// Command and data halves of a write may land on different edges
			if (wrAddrQ.size() > 0 && wrDataQ.size() > 0)
				mem[wrAddrQ.pop_front()] = wrDataQ.pop_front();
			if (rdTaken) begin
				rdValidQ = 1'b0;
				rdTaken = 1'b0;
			end
			r = $random(seed);
			if (!rdValidQ && rdQ.size() > 0 && (!stallEn || r[2])) begin
				rdDataQ = mem[rdQ.pop_front()];
				rdValidQ = 1'b1;
			end
			cmdRdyQ = !stallEn || r[0];
			wrRdyQ = !stallEn || r[1];
		end
	end

endmodule

//--- PathOramBackendTb.sv
// Path ORAM backend testbench
// Directed and random accesses against a reference model of the tree
`timescale 1ns/1ps

module PathOramBackendTb
	import OramPkg::*;
();

	localparam int SeedInit = 32'hf209;
	localparam int NumAccesses = 41;
	localparam int WatchdogNs = NumAccesses * 40000;
	localparam int WaitLimit = 2000;

	logic Clock;
	logic rst;
	backendCmd_t Command;
	logic [AddrW-1:0] PAddr;
	logic [OramL-1:0] CurrentLeaf;
	logic [OramL-1:0] RemappedLeaf;
	logic CommandValid;
	logic CommandReady;
	logic [DataW-1:0] LoadData;
	logic LoadValid;
	logic LoadReady;
	logic [DataW-1:0] StoreData;
	logic StoreValid;
	logic StoreReady;
	logic [DramAW-1:0] DRAMCommandAddress;
	dramCmd_t DRAMCommand;
	logic DRAMCommandValid;
	logic DRAMCommandReady;
	logic [SlotW-1:0] DRAMReadData;
	logic DRAMReadDataValid;
	logic DRAMReadDataReady;
	logic [SlotW-1:0] DRAMWriteData;
	logic DRAMWriteDataValid;
	logic DRAMWriteDataReady;
	logic stallEn;
	logic [DramAW-1:0] peekAddr;
	logic [SlotW-1:0] peekData;

	// Reference model, address to (leaf, data)
	logic modelValid [1 << AddrW];
	logic [OramL-1:0] modelLeaf [1 << AddrW];
	logic [DataW-1:0] modelData [1 << AddrW];
	logic cmdLogRead [$];
	logic [DramAW-1:0] cmdLogAddr [$];
	int valueErrors = 0;
	int otherErrors = 0;
	integer seed = SeedInit;

	PathOramBackend dut_i (.*);

	DramModel #(.Seed(SeedInit)) dram_i (
		.Clock(Clock),
		.rst(rst),
		.stallEn(stallEn),
		.cmdAddr(DRAMCommandAddress),
		.cmd(DRAMCommand),
		.cmdValid(DRAMCommandValid),
		.cmdReady(DRAMCommandReady),
		.rdData(DRAMReadData),
		.rdValid(DRAMReadDataValid),
		.rdReady(DRAMReadDataReady),
		.wrData(DRAMWriteData),
		.wrValid(DRAMWriteDataValid),
		.wrReady(DRAMWriteDataReady),
		.peekAddr(peekAddr),
		.peekData(peekData)
	);

	initial begin
		Clock = 1'b0;
		forever #50 Clock = ~Clock;
	end

	// Every accepted DRAM command, in order
	always @(posedge Clock) begin
		if (!rst && DRAMCommandValid && DRAMCommandReady) begin
			cmdLogRead.push_back(DRAMCommand == DramRead);
			cmdLogAddr.push_back(DRAMCommandAddress);
		end
	end

	initial begin
		#(WatchdogNs);
		$display("Timeout: the run did not finish within %0d ns", WatchdogNs);
		$display("Result: FAILED");
		$finish;
	end

	// ----------------------------------------------------------
	// Expected values from the tree rules
	// ----------------------------------------------------------
	function automatic logic [SlotW-1:0] slotPad(input logic [DramAW-1:0] addr);
		logic [SlotW-1:0] rot;
		logic [SlotW-1:0] rep;
		int sh;
		sh = (3 * int'(addr)) % SlotW;
		rot = CipherKey;
		for (int i = 0; i < sh; i++)
			rot = {rot[SlotW-2:0], rot[SlotW-1]};
		for (int i = 0; i < SlotW; i++)
			rep[i] = addr[i % DramAW];
		return rot ^ rep;
	endfunction

	// Word 0 is the leaf-level bucket's first slot
	function automatic logic [DramAW-1:0] pathSlot(input logic [OramL-1:0] leaf, input int word);
		int level;
		int bucket;
		level = OramL - word / OramZ;
		bucket = (1 << level) - 1 + (int'(leaf) >> (OramL - level));
		return DramAW'(bucket * OramZ + word % OramZ);
	endfunction

	function automatic int bucketLevel(input int bucket);
		int level;
		level = 0;
		while (bucket >= (2 << level) - 1)
			level++;
		return level;
	endfunction

	// ----------------------------------------------------------
	// Handshake helpers, all entered on a falling edge
	// ----------------------------------------------------------
	task automatic waitCmdReady();
		int n;
		n = 0;
		while (!CommandReady && n < WaitLimit) begin
			@(negedge Clock);
			n++;
		end
		if (!CommandReady) begin
			$display("CommandReady did not rise within %0d cycles", WaitLimit);
			otherErrors++;
		end
	endtask

	task automatic waitStoreTaken();
		int n;
		n = 0;
		while (!StoreReady && n < WaitLimit) begin
			@(negedge Clock);
			n++;
		end
		if (!StoreReady) begin
			$display("StoreReady did not rise within %0d cycles", WaitLimit);
			otherErrors++;
		end else begin
			@(negedge Clock);
		end
		StoreValid = 1'b0;
	endtask

	// Reset and idle both leave every other handshake output low
	task automatic checkQuietOutputs();
		if (LoadValid !== 1'b0) begin
			$display("[ERROR] LoadValid: got %h, expected %h", LoadValid, 1'b0);
			valueErrors++;
		end
		if (StoreReady !== 1'b0) begin
			$display("[ERROR] StoreReady: got %h, expected %h", StoreReady, 1'b0);
			valueErrors++;
		end
		if (DRAMCommandValid !== 1'b0) begin
			$display("[ERROR] DRAMCommandValid: got %h, expected %h",
				DRAMCommandValid, 1'b0);
			valueErrors++;
		end
		if (DRAMWriteDataValid !== 1'b0) begin
			$display("[ERROR] DRAMWriteDataValid: got %h, expected %h",
				DRAMWriteDataValid, 1'b0);
			valueErrors++;
		end
		if (DRAMReadDataReady !== 1'b0) begin
			$display("[ERROR] DRAMReadDataReady: got %h, expected %h",
				DRAMReadDataReady, 1'b0);
			valueErrors++;
		end
	endtask

	task automatic checkPathLog(input int logStart, input logic [OramL-1:0] leaf);
		if (cmdLogAddr.size() - logStart != 2 * PathSlots) begin
			$display("Access issued %0d DRAM commands instead of %0d",
				cmdLogAddr.size() - logStart, 2 * PathSlots);
			otherErrors++;
		end else begin
			for (int w = 0; w < 2 * PathSlots; w++) begin
				if (cmdLogRead[logStart + w] !== (w < PathSlots)) begin
					$display("[ERROR] DRAMCommand (is read) #%0d: got %h, expected %h",
						w, cmdLogRead[logStart + w], w < PathSlots);
					valueErrors++;
				end
				if (cmdLogAddr[logStart + w] !== pathSlot(leaf, w % PathSlots)) begin
					$display("[ERROR] DRAMCommandAddress #%0d: got %h, expected %h",
						w, cmdLogAddr[logStart + w], pathSlot(leaf, w % PathSlots));
					valueErrors++;
				end
			end
		end
	endtask

	// Decodes every DRAM word and checks placement against the model
	task automatic checkTree();
		logic [SlotW-1:0] dec;
		logic [AddrW-1:0] a;
		logic [OramL-1:0] leaf;
		logic seen [1 << AddrW];
		int bucket;
		int level;
		for (int i = 0; i < (1 << AddrW); i++)
			seen[i] = 1'b0;
		for (int i = 0; i < NumSlots; i++) begin
			peekAddr = DramAW'(i);
			#1;
			dec = peekData ^ slotPad(DramAW'(i));
			bucket = i / OramZ;
			level = bucketLevel(bucket);
			if (!dec[SlotW-1]) begin
				if (dec !== '0) begin
					$display("[ERROR] DRAM word %0d decoded: got %h, expected %h", i, dec, 0);
					valueErrors++;
				end
			end else begin
				a = dec[DataW + OramL +: AddrW];
				leaf = dec[DataW +: OramL];
				if (seen[a]) begin
					$display("Block %h appears twice in DRAM", a);
					otherErrors++;
				end
				seen[a] = 1'b1;
				if ((int'(leaf) >> (OramL - level)) != bucket - ((1 << level) - 1)) begin
					$display("Block %h with leaf %0d sits off its path in bucket %0d",
						a, leaf, bucket);
					otherErrors++;
				end
				if (!modelValid[a]) begin
					$display("DRAM word %0d holds block %h that was never accessed", i, a);
					otherErrors++;
				end else begin
					if (leaf !== modelLeaf[a]) begin
						$display("[ERROR] leaf of block %h: got %h, expected %h",
							a, leaf, modelLeaf[a]);
						valueErrors++;
					end
					if (dec[DataW-1:0] !== modelData[a]) begin
						$display("[ERROR] data of block %h: got %h, expected %h",
							a, dec[DataW-1:0], modelData[a]);
						valueErrors++;
					end
				end
			end
		end
		// Back onto the falling edge for the next stimulus
		@(negedge Clock);
	endtask

	// ----------------------------------------------------------
	// One frontend command
	// ----------------------------------------------------------
	task automatic runAccess(input backendCmd_t cmd, input logic [AddrW-1:0] addr,
		input logic [OramL-1:0] remap, input logic [DataW-1:0] data);
		int logStart;
		int n;
		logic [OramL-1:0] cur;
		logic [DataW-1:0] expData;
		logic [DataW-1:0] held;
		logic [31:0] r;
		waitCmdReady();
		cur = modelValid[addr] ? modelLeaf[addr] : addr[OramL-1:0];
		expData = modelValid[addr] ? modelData[addr] : '0;
		logStart = cmdLogAddr.size();
		Command = cmd;
		PAddr = addr;
		CurrentLeaf = cur;
		RemappedLeaf = remap;
		StoreData = data;
		StoreValid = (cmd == Write);
		CommandValid = 1'b1;
		@(negedge Clock);
		CommandValid = 1'b0;
		if (cmd == Write) begin
			waitStoreTaken();
		end else begin
			n = 0;
			while (!LoadValid && n < WaitLimit) begin
				@(negedge Clock);
				n++;
			end
			if (!LoadValid) begin
				$display("LoadValid did not rise within %0d cycles", WaitLimit);
				otherErrors++;
			end else begin
				held = LoadData;
				r = $random(seed);
				// Back-pressure on the load port
				repeat (stallEn ? r[1:0] : 2'd0) begin
					@(negedge Clock);
					if (!LoadValid) begin
						$display("LoadValid dropped before LoadReady was given");
						otherErrors++;
					end
					if (LoadData !== held) begin
						$display("[ERROR] LoadData under stall: got %h, expected %h",
							LoadData, held);
						valueErrors++;
					end
				end
				LoadReady = 1'b1;
				@(negedge Clock);
				LoadReady = 1'b0;
				if (held !== expData) begin
					$display("[ERROR] LoadData for address %h: got %h, expected %h",
						addr, held, expData);
					valueErrors++;
				end
			end
		end
		waitCmdReady();
		checkQuietOutputs();
		modelValid[addr] = 1'b1;
		modelLeaf[addr] = remap;
		modelData[addr] = (cmd == Write) ? data : expData;
		checkPathLog(logStart, cur);
		checkTree();
	endtask

	task automatic runAppend(input logic [AddrW-1:0] addr, input logic [OramL-1:0] remap,
		input logic [DataW-1:0] data);
		int logStart;
		waitCmdReady();
		logStart = cmdLogAddr.size();
		Command = Append;
		PAddr = addr;
		CurrentLeaf = remap;
		RemappedLeaf = remap;
		StoreData = data;
		StoreValid = 1'b1;
		CommandValid = 1'b1;
		@(negedge Clock);
		CommandValid = 0;
		waitStoreTaken();
		if (!CommandReady) begin
			$display("CommandReady did not return one cycle after the Append store");
			otherErrors++;
		end
		waitCmdReady();
		checkQuietOutputs();
		if (cmdLogAddr.size() != logStart) begin
			$display("Append issued %0d DRAM commands", cmdLogAddr.size() - logStart);
			otherErrors++;
		end
		modelValid[addr] = 1'b1;
		modelLeaf[addr] = remap;
		modelData[addr] = data;
		checkTree();
	endtask

	// ----------------------------------------------------------
	// Tests
	// ----------------------------------------------------------
	task automatic testInit();
		if (CommandReady !== 1'b0) begin
			$display("[ERROR] CommandReady after reset: got %h, expected %h",
				CommandReady, 1'b0);
			valueErrors++;
		end
		checkQuietOutputs();
		waitCmdReady();
		if (cmdLogAddr.size() != NumSlots) begin
			$display("%0d DRAM commands before CommandReady rose, expected %0d",
				cmdLogAddr.size(), NumSlots);
			otherErrors++;
		end
		for (int i = 0; i < cmdLogAddr.size(); i++) begin
			if (cmdLogRead[i] !== 1'b0) begin
				$display("[ERROR] DRAMCommand (is read) init write #%0d: got %h, expected %h",
					i, cmdLogRead[i], 1'b0);
				valueErrors++;
			end
			if (cmdLogAddr[i] !== DramAW'(i)) begin
				$display("[ERROR] DRAMCommandAddress init write #%0d: got %h, expected %h",
					i, cmdLogAddr[i], DramAW'(i));
				valueErrors++;
			end
		end
		checkTree();
	endtask

	task automatic testWriteRead();
		runAccess(Write, 4'h3, 2'd2, 32'hCAFE_0003);
		runAccess(Read, 4'h3, 2'd1, '0);
		runAccess(Read, 4'h5, 2'd0, '0);
	endtask

	// Current leaf walks through all four paths
	task automatic testAllLeaves();
		runAccess(Write, 4'h6, 2'd0, 32'h6000_0001);
		runAccess(Write, 4'h6, 2'd1, 32'h6000_0002);
		runAccess(Read, 4'h6, 2'd3, '0);
		runAccess(Write, 4'h6, 2'd2, 32'h6000_0004);
		runAccess(Read, 4'h6, 2'd0, '0);
	endtask

	task automatic testAppend();
		runAppend(4'h7, 2'd1, 32'h7777_ABCD);
		runAccess(Read, 4'h7, 2'd3, '0);
	endtask

	task automatic testRandom();
		logic [31:0] r;
		logic [AddrW-1:0] addr;
		stallEn = 1'b1;
		// Pool of 8 addresses keeps the block count within the stash size
		for (int n = 0; n < 30; n++) begin
			r = $random(seed);
			addr = {1'b0, r[2:0]};
			if (!modelValid[addr] && r[4:3] == 2'd0)
				runAppend(addr, r[6:5], $random(seed));
			else if (r[7])
				runAccess(Write, addr, r[6:5], $random(seed));
			else
				runAccess(Read, addr, r[6:5], '0);
		end
		stallEn = 1'b0;
	endtask

	initial begin
		rst = 1'b1;
		Command = Read;
		PAddr = '0;
		CurrentLeaf = '0;
		RemappedLeaf = '0;
		CommandValid = 1'b0;
		LoadReady = 1'b0;
		StoreData = '0;
		StoreValid = 1'b0;
		stallEn = 1'b0;
		peekAddr = '0;
		for (int i = 0; i < (1 << AddrW); i++)
			modelValid[i] = 1'b0;
		repeat (2) @(negedge Clock);
		rst = 1'b0;
		testInit();
		testWriteRead();
		testAllLeaves();
		testAppend();
		testRandom();
		$display("Checks done: %0d value errors, %0d other errors", valueErrors, otherErrors);
		if (valueErrors + otherErrors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

//--- filelist.f
OramPkg.sv
PathAddrGen.sv
Stash.sv
BucketCipher.sv
BackendCtrl.sv
PathOramBackend.sv
DramModel.sv
PathOramBackendTb.sv

//--- run.sh
#!/bin/sh
# Build and run the Path ORAM backend testbench with Verilator
verilator --binary --timing --assert -j 0 --top-module PathOramBackendTb \
	-f filelist.f -o simv > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -q "Result: FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
